// ==== src/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   // address geometry
   localparam int addr_w     = 16;
   localparam int line_bytes = 16;
   localparam int line_w     = line_bytes * 8;
   localparam int num_lines  = 32;
   localparam int tag_w      = 7;
   localparam int index_w    = 5;
   localparam int offset_w   = 4;

   typedef logic [line_w-1:0]     line_t;
   typedef logic [line_bytes-1:0] byte_mask_t;

   // byte address, tag on top
   typedef struct packed {
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] offset;
   } addr_t;

   // access size in bytes, 15 means the whole line
   typedef logic [3:0] size_t;
   localparam size_t size_line = 4'd15;

   // one-hot controller states
   typedef enum logic [8:0] {
      idle     = 9'b0_0000_0001,
      rd       = 9'b0_0000_0010,
      rd_hit   = 9'b0_0000_0100,
      rd_miss  = 9'b0_0000_1000,
      rd_evict = 9'b0_0001_0000,
      wr       = 9'b0_0010_0000,
      wr_hit   = 9'b0_0100_0000,
      wr_miss  = 9'b0_1000_0000,
      wr_evict = 9'b1_0000_0000
   } state_t;

   // processor request, only low bytes of wdata matter
   typedef struct packed {
      logic  rw;
      addr_t addr;
      size_t size;
      line_t wdata;
   } cpu_req_t;

   // line-wide memory bus, offset always zero
   typedef struct packed {
      logic  en;
      logic  wr;
      addr_t addr;
      line_t wdata;
   } bus_req_t;

endpackage

`default_nettype wire

// ==== src/cache_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module cache_ctrl (
   input  logic clk,
   input  logic rst_n,
   input  logic enable,
   input  logic rw,
   input  logic hit,
   input  logic evict,
   input  logic bus_r,
   output logic line_wr,
   output logic fill_sel,
   output logic tag_wr,
   output logic bus_en,
   output logic bus_wr,
   output logic ready
);

   cache_pkg::state_t state;
   cache_pkg::state_t state_nxt;

   // state register
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state <= cache_pkg::idle;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         cache_pkg::idle:
         begin
            // accept a request and split by direction
            if (enable)
               state_nxt = rw ? cache_pkg::wr : cache_pkg::rd;
         end
         cache_pkg::rd:
         begin
            // tag lookup settles during this cycle
            if (hit)
               state_nxt = cache_pkg::rd_hit;
            else if (evict)
               state_nxt = cache_pkg::rd_evict;
            else
               state_nxt = cache_pkg::rd_miss;
         end
         cache_pkg::rd_miss:
         begin
            if (bus_r)
               state_nxt = cache_pkg::rd_hit;
         end
         cache_pkg::rd_evict:
         begin
            // old line written back so fetch the new one
            if (bus_r)
               state_nxt = cache_pkg::rd_miss;
         end
         cache_pkg::wr:
         begin
            if (hit)
               state_nxt = cache_pkg::wr_hit;
            else if (evict)
               state_nxt = cache_pkg::wr_evict;
            else
               state_nxt = cache_pkg::wr_miss;
         end
         cache_pkg::wr_miss:
         begin
            // allocate on write by filling first
            if (bus_r)
               state_nxt = cache_pkg::wr_hit;
         end
         cache_pkg::wr_evict:
         begin
            if (bus_r)
               state_nxt = cache_pkg::wr_miss;
         end
         default:
            state_nxt = cache_pkg::idle;
      endcase
   end

   // strobes straight from the state
   assign fill_sel = (state == cache_pkg::rd_miss) || (state == cache_pkg::wr_miss);
   assign bus_wr   = (state == cache_pkg::rd_evict) || (state == cache_pkg::wr_evict);
   assign bus_en   = fill_sel || bus_wr;
   assign ready    = (state == cache_pkg::rd_hit) || (state == cache_pkg::wr_hit);
   assign tag_wr   = ready;
   // fill lands with bus_r and processor bytes land in wr_hit
   assign line_wr  = (fill_sel && bus_r) || (state == cache_pkg::wr_hit);

   a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot(state));

   a_ready_no_bus: assert property (@(posedge clk) disable iff (!rst_n)
      !(ready && bus_en));

endmodule

`default_nettype wire

// ==== src/tag_store.sv ====
`default_nettype none
`timescale 1ns/10ps

module tag_store (
   input  logic             clk,
   input  logic             rst_n,
   input  cache_pkg::addr_t addr,
   input  logic             tag_wr,
   output logic             hit,
   output logic             evict
);

   // one tag per line
   logic [cache_pkg::tag_w-1:0]   tags [cache_pkg::num_lines];
   logic [cache_pkg::num_lines-1:0] valid;
   logic                            tag_match;
   logic                            line_valid;

   // valid bits cleared on reset, lines never invalidated
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         valid <= '0;
      else if (tag_wr)
         valid[addr.index] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (tag_wr)
         tags[addr.index] <= addr.tag;
   end

   // combinational lookup
   assign line_valid = valid[addr.index];
   assign tag_match  = (tags[addr.index] == addr.tag);

   assign hit   = line_valid && tag_match;
   // a valid line owned by another tag must go out first
   assign evict = line_valid && !tag_match;

   a_hit_evict_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(hit && evict));

endmodule

`default_nettype wire

// ==== src/data_array.sv ====
`default_nettype none
`timescale 1ns/10ps

module data_array (
   input  logic                            clk,
   input  logic [cache_pkg::index_w-1:0]   index,
   input  cache_pkg::line_t                wdata,
   input  cache_pkg::byte_mask_t           byte_we,
   output cache_pkg::line_t                rdata
);

   // line storage
   cache_pkg::line_t mem [cache_pkg::num_lines];

   // per-byte write enables
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < cache_pkg::line_bytes; b++)
      begin
         if (byte_we[b])
            mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
      end
   end

   // whole line out, no output register
   assign rdata = mem[index];

endmodule

`default_nettype wire

// ==== src/write_align.sv ====
`default_nettype none
`timescale 1ns/10ps

module write_align (
   input  logic [cache_pkg::offset_w-1:0] offset,
   input  cache_pkg::size_t               size,
   input  cache_pkg::line_t               wdata,
   output cache_pkg::line_t               data,
   output cache_pkg::byte_mask_t          mask
);

   cache_pkg::byte_mask_t base_mask;

   // move byte 0 of the request up to the offset byte
   assign data = wdata << {offset, 3'b000};

   always_comb
   begin
      // size ones at the bottom, 1 gives 0x0001, 8 gives 0x00ff
      base_mask = (cache_pkg::byte_mask_t'(1) << size) - cache_pkg::byte_mask_t'(1);
      if (size == cache_pkg::size_line)
      begin
         // whole line regardless of offset
         mask = '1;
      end
      else
      begin
         // bytes shifted past the top of the line fall off
         mask = base_mask << offset;
      end
   end

endmodule

`default_nettype wire

// ==== src/cache_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module cache_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enable,
   input  cache_pkg::cpu_req_t   req,
   output cache_pkg::line_t      data_read,
   output logic                  ready,
   output cache_pkg::bus_req_t   bus,
   input  logic                  bus_r,
   input  cache_pkg::line_t      bus_read
);

   logic                          hit;
   logic                          evict;
   logic                          line_wr;
   logic                          fill_sel;
   logic                          tag_wr;
   logic                          bus_en;
   logic                          bus_wr;
   cache_pkg::line_t              align_data;
   cache_pkg::byte_mask_t         align_mask;
   cache_pkg::line_t              array_wdata;
   cache_pkg::byte_mask_t         array_we;
   cache_pkg::line_t              line_rd;
   logic [cache_pkg::addr_w-1:0]  line_addr;

   cache_ctrl u_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (enable),
      .rw       (req.rw),
      .hit      (hit),
      .evict    (evict),
      .bus_r    (bus_r),
      .line_wr  (line_wr),
      .fill_sel (fill_sel),
      .tag_wr   (tag_wr),
      .bus_en   (bus_en),
      .bus_wr   (bus_wr),
      .ready    (ready)
   );

   tag_store u_tags (
      .clk    (clk),
      .rst_n  (rst_n),
      .addr   (req.addr),
      .tag_wr (tag_wr),
      .hit    (hit),
      .evict  (evict)
   );

   write_align u_align (
      .offset (req.addr.offset),
      .size   (req.size),
      .wdata  (req.wdata),
      .data   (align_data),
      .mask   (align_mask)
   );

   // fill takes the whole bus line, otherwise processor bytes
   assign array_wdata = fill_sel ? bus_read : align_data;
   assign array_we    = line_wr ? (fill_sel ? '1 : align_mask) : '0;

   data_array u_data (
      .clk     (clk),
      .index   (req.addr.index),
      .wdata   (array_wdata),
      .byte_we (array_we),
      .rdata   (line_rd)
   )
   ;

   // line address on the bus, offset forced to zero
   assign line_addr = {req.addr.tag, req.addr.index, {cache_pkg::offset_w{1'b0}}};

   // evict data is the line before the fill overwrites it
   assign bus = '{en: bus_en, wr: bus_wr, addr: line_addr, wdata: line_rd};
   assign data_read = line_rd;

endmodule

`default_nettype wire

// ==== testbench/cache_model.svh ====
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// reference cache, one entry per index
logic                        model_valid [cache_pkg::num_lines];
logic [cache_pkg::tag_w-1:0] model_tag [cache_pkg::num_lines];
cache_pkg::line_t            model_line [cache_pkg::num_lines];
// expected backing memory, 4096 lines of 16 bytes
cache_pkg::line_t            model_mem [4096];

// start-up memory contents, each byte built from its full address
function automatic cache_pkg::line_t fill_line(input logic [11:0] line_addr);
   cache_pkg::line_t l;
   logic [15:0]      a;
   for (int b = 0; b < cache_pkg::line_bytes; b++)
   begin
      a = {line_addr, 4'(b)};
      l[b*8 +: 8] = (a[7:0] ^ a[15:8]) + {a[3:0], a[11:8]};
   end
   return l;
endfunction

task automatic abort_run(input string why);
   $display("%s", why);
   $display("Result: FAILED");
   $fatal(1);
endtask

task automatic check_line(input string name, input cache_pkg::line_t got,
                          input cache_pkg::line_t exp);
   if (got !== exp)
      abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
endtask

task automatic check_addr(input string name, input cache_pkg::addr_t got,
                          input cache_pkg::addr_t exp);
   if (got !== exp)
      abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp)
      abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
endtask

// predict one access, updates model cache and memory
task automatic model_access(input cache_pkg::cpu_req_t r, output logic hit,
                            output logic evict, output cache_pkg::line_t old_line,
                            output cache_pkg::line_t line_after);
   int          idx;
   int          src;
   logic [11:0] la;
   idx      = r.addr.index;
   la       = {r.addr.tag, r.addr.index};
   hit      = model_valid[idx] && (model_tag[idx] == r.addr.tag);
   evict    = model_valid[idx] && !hit;
   old_line = model_line[idx];
   // write-back lands at the requested line address
   if (evict)
      model_mem[la] = model_line[idx];
   if (!hit)
   begin
      model_line[idx]  = model_mem[la];
      model_valid[idx] = 1'b1;
      model_tag[idx]   = r.addr.tag;
   end
   if (r.rw)
   begin
      for (int b = 0; b < cache_pkg::line_bytes; b++)
      begin
         src = b - int'(r.addr.offset);
         // bytes past byte 15 are lost
         if (src >= 0 && (r.size == cache_pkg::size_line || src < int'(r.size)))
            model_line[idx][b*8 +: 8] = r.wdata[src*8 +: 8];
         else if (r.size == cache_pkg::size_line)
            model_line[idx][b*8 +: 8] = 8'h00;
      end
   end
   line_after = model_line[idx];
endtask

`endif

// ==== testbench/cache_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module cache_tb;

   localparam int num_txn    = 400;
   localparam int clk_period = 40;

   logic                clk;
   logic                rst_n;
   logic                enable;
   cache_pkg::cpu_req_t req;
   cache_pkg::line_t    data_read;
   logic                ready;
   cache_pkg::bus_req_t bus;
   logic                bus_r;
   cache_pkg::line_t    bus_read;

   integer              seed = 1806;
   // memory behind the bus, 64K bytes
   cache_pkg::line_t    bus_mem [4096];
   int                  resp_wait;

   `include "cache_model.svh"

   cache_top DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .enable    (enable),
      .req       (req),
      .data_read (data_read),
      .ready     (ready),
      .bus       (bus),
      .bus_r     (bus_r),
      .bus_read  (bus_read)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // 20 cycles per transaction is far above the worst evict plus fill
   initial
   begin
      #(num_txn * 20 * clk_period);
      abort_run("timeout, the test did not finish in time");
   end

   // bus responder, answers after 0 to 3 cycles
   initial
   begin
      bus_r    = 1'b0;
      bus_read = '0;
      forever
      begin
         @(posedge clk);
         #2;
         bus_r = 1'b0;
         if (rst_n === 1'b1 && bus.en === 1'b1)
         begin
            resp_wait = {$random(seed)} % 4;
            repeat (resp_wait)
            begin
               @(posedge clk);
               #2;
            end
            if (bus.wr)
               bus_mem[{bus.addr.tag, bus.addr.index}] = bus.wdata;
            else
               bus_read = bus_mem[{bus.addr.tag, bus.addr.index}];
            bus_r = 1'b1;
         end
      end
   end

   // few tags and indices so lines collide often
   task automatic make_req(output cache_pkg::cpu_req_t r);
      cache_pkg::size_t sizes [5] = '{4'd1, 4'd2, 4'd4, 4'd8, cache_pkg::size_line};
      r.rw          = 1'($random(seed));
      r.addr.tag    = 7'({$random(seed)} % 3);
      r.addr.index  = 5'({$random(seed)} % 8);
      r.addr.offset = 4'($random(seed));
      r.size        = sizes[{$random(seed)} % 5];
      r.wdata       = {$random(seed), $random(seed), $random(seed), $random(seed)};
   endtask

   // one request, watched cycle by cycle until ready
   task automatic run_txn(input cache_pkg::cpu_req_t r);
      logic             exp_hit;
      logic             exp_evict;
      cache_pkg::line_t exp_old;
      cache_pkg::line_t exp_line;
      cache_pkg::addr_t line_addr;
      int               cycles;
      int               xfers;
      logic             done;
      model_access(r, exp_hit, exp_evict, exp_old, exp_line);
      line_addr        = r.addr;
      line_addr.offset = '0;
      @(posedge clk);
      #2;
      enable = 1'b1;
      req    = r;
      cycles = 0;
      xfers  = 0;
      done   = 1'b0;
      while (!done)
      begin
         @(negedge clk);
         cycles++;
         // idle, lookup, then hit state with ready
         if (exp_hit)
         begin
            check_flag("ready", ready, cycles == 3);
            check_flag("bus.en", bus.en, 1'b0);
         end
         if (bus.en && bus_r)
         begin
            xfers++;
            if (xfers > (exp_evict ? 2 : 1))
               abort_run("unexpected bus transfer during the access");
            check_addr("bus.addr", bus.addr, line_addr);
            // write-back first, then the fill
            check_flag("bus.wr", bus.wr, exp_evict && xfers == 1);
            if (bus.wr)
               check_line("bus.wdata", bus.wdata, exp_old);
         end
         done = ready;
      end
      if (!exp_hit && xfers != (exp_evict ? 2 : 1))
         abort_run("bus transfer missing before ready");
      if (!r.rw)
         check_line("data_read", data_read, exp_line);
      if (exp_evict)
         check_line("backing memory", bus_mem[{r.addr.tag, r.addr.index}],
                    model_mem[{r.addr.tag, r.addr.index}]);
      @(posedge clk);
      #2;
      enable = 1'b0;
   endtask

   initial
   begin : stimulus
      cache_pkg::cpu_req_t r;
      rst_n       = 1'b0;
      enable      = 1'b0;
      req         = '0;
      model_valid = '{default: 1'b0};
      for (int i = 0; i < 4096; i++)
      begin
         model_mem[i] = fill_line(12'(i));
         bus_mem[i]   = model_mem[i];
      end
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      check_flag("ready", ready, 1'b0);
      check_flag("bus.en", bus.en, 1'b0);
      // cold read, must miss without write-back
      make_req(r);
      r.rw = 1'b0;
      run_txn(r);
      for (int n = 1; n < num_txn; n++)
      begin
         make_req(r);
         run_txn(r);
      end
      // whole backing memory against the model
      for (int i = 0; i < 4096; i++)
         check_line($sformatf("bus_mem[%0h]", i), bus_mem[i], model_mem[i]);
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+testbench
src/cache_pkg.sv
src/cache_ctrl.sv
src/tag_store.sv
src/data_array.sv
src/write_align.sv
src/cache_top.sv
testbench/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  - src/cache_pkg.sv
  - src/cache_ctrl.sv
  - src/tag_store.sv
  - src/data_array.sv
  - src/write_align.sv
  - src/cache_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/cache_tb.sv
